/* hdl/flash_settings.svh */
`ifndef FLASH_SETTINGS_SVH
`define FLASH_SETTINGS_SVH

// address and data widths
`define FLASH_ADDR_W 24
`define SRAM_ADDR_W 18
`define SRAM_DATA_W 16

// command fields
`define OPCODE_W 8
`define CMD_LEN_W 9

// flash geometry
`define PAGE_BYTES 256
`define SECTOR_PAGES 256
`define REGION_PAGES 2

// serial clock and fixed waits in 50 MHz cycles
`define SPI_HALF_CYCLES 2
`define TIMER_W 16
`define READ_SETTLE_CYCLES 250
`define PROGRAM_WAIT_CYCLES 2000
`define ERASE_WAIT_CYCLES 4000

`endif

/* hdl/flash_types_pkg.sv */
`include "flash_settings.svh"

package flash_types_pkg;

	// sequencer FSM
	typedef enum logic [3:0] {
		IDLE,
		LOAD_CMD,
		LOAD_RUN,
		LOAD_SETTLE,
		READY,
		ERASE_CMD,
		ERASE_WAIT,
		PROG_CMD,
		PROG_WAIT,
		VERIFY_START
	} seq_state_t;

	// SPI NOR opcodes in use
	typedef enum logic [`OPCODE_W-1:0] {
		OP_PROGRAM = 8'h02,
		OP_READ    = 8'h03,
		OP_ERASE   = 8'hD8
	} flash_op_t;

endpackage

/* hdl/flash_map_pkg.sv */
`include "flash_settings.svh"

package flash_map_pkg;

	typedef logic [`FLASH_ADDR_W-1:0] flash_addr_t;
	typedef logic [`SRAM_ADDR_W-1:0] sram_addr_t;

	typedef enum logic {
		REGION_USER,
		REGION_FACTORY
	} region_t;

	localparam flash_addr_t FLASH_USER_BASE    = 24'h0A0000;
	localparam flash_addr_t FLASH_FACTORY_BASE = 24'h0B0000;
	localparam sram_addr_t  SRAM_USER_BASE     = 18'h00000;
	localparam sram_addr_t  SRAM_FACTORY_BASE  = 18'h08000;

	function automatic flash_addr_t flash_base(region_t region);
		return (region == REGION_FACTORY) ? FLASH_FACTORY_BASE : FLASH_USER_BASE;
	endfunction

	function automatic sram_addr_t sram_base(region_t region);
		return (region == REGION_FACTORY) ? SRAM_FACTORY_BASE : SRAM_USER_BASE;
	endfunction

endpackage

/* hdl/spi_cmd_if.sv */
`timescale 1ns/1ns
`include "flash_settings.svh"

interface spi_cmd_if;
	import flash_types_pkg::*;
	import flash_map_pkg::*;

	// one command per CS frame
	logic                  cmd_valid;
	logic                  cmd_ready;
	flash_op_t             cmd_op;
	flash_addr_t           cmd_addr;
	logic [`CMD_LEN_W-1:0] cmd_len;
	logic                  cmd_done;

	// byte streams without back-pressure
	logic                  tx_req;
	logic [7:0]            tx_byte;
	logic                  rx_valid;
	logic [7:0]            rx_byte;

	modport seq (
		output cmd_valid, cmd_op, cmd_addr, cmd_len,
		input  cmd_ready, cmd_done
	);

	modport engine (
		input  cmd_valid, cmd_op, cmd_addr, cmd_len, tx_byte,
		output cmd_ready, cmd_done, tx_req, rx_valid, rx_byte
	);

	modport mover (
		input  tx_req, rx_valid, rx_byte,
		output tx_byte
	);

endinterface

/* hdl/flash_wait_timer.sv */
`timescale 1ns/1ns
`include "flash_settings.svh"

module flash_wait_timer (
	input  logic                i_clk_50m,
	input  logic                i_rst_n,
	input  logic                i_load,
	input  logic [`TIMER_W-1:0] i_cycles,
	output logic                o_done
);

	logic [`TIMER_W-1:0] r_count;

	// stops at zero until reloaded
	always_ff @(posedge i_clk_50m or negedge i_rst_n) begin
		if (!i_rst_n) begin
			r_count <= '0;
		end else if (i_load) begin
			r_count <= i_cycles;
		end else if (r_count != '0) begin
			r_count <= r_count - 1'b1;
		end
	end

	assign o_done = (r_count == '0);

endmodule

/* hdl/flash_sequencer.sv */
`timescale 1ns/1ns
`include "flash_settings.svh"

module flash_sequencer (
	input  logic                     i_clk_50m,
	input  logic                     i_rst_n,
	input  logic                     i_load_user,
	input  logic                     i_save_user,
	input  logic                     i_save_factory,
	spi_cmd_if.seq                   cmd,
	output logic                     o_timer_load,
	output logic [`TIMER_W-1:0]      o_timer_cycles,
	input  logic                     i_timer_done,
	output logic                     o_move_start,
	output flash_map_pkg::sram_addr_t o_move_base,
	output logic                     o_move_drain,
	output logic                     o_busy,
	output logic                     o_load_done
);
	import flash_types_pkg::*;
	import flash_map_pkg::*;

	localparam int PAGE_W = $clog2(`REGION_PAGES + 1);

	seq_state_t        r_state;
	region_t           r_region;
	logic [PAGE_W-1:0] r_page_cnt;
	flash_addr_t       r_flash_addr;
	logic              r_timing;
	logic              w_accepted;
	logic              w_last_page;
	logic              w_start_load;
	logic              w_start_save;
	region_t           w_load_region;
	region_t           w_save_region;

	assign w_accepted  = cmd.cmd_valid && cmd.cmd_ready;
	assign w_last_page = (r_page_cnt == PAGE_W'(`REGION_PAGES - 1));

	assign cmd.cmd_valid = (r_state == LOAD_CMD) || (r_state == ERASE_CMD) ||
		(r_state == PROG_CMD);
	assign cmd.cmd_addr  = r_flash_addr;

	always_comb begin
		case (r_state)
			ERASE_CMD: begin
				cmd.cmd_op  = OP_ERASE;
				cmd.cmd_len = '0;
			end
			PROG_CMD: begin
				cmd.cmd_op  = OP_PROGRAM;
				cmd.cmd_len = `CMD_LEN_W'(`PAGE_BYTES);
			end
			default: begin
				cmd.cmd_op  = OP_READ;
				cmd.cmd_len = `CMD_LEN_W'(`PAGE_BYTES);
			end
		endcase
	end

	// wait starts on the edge that ends the frame
	always_comb begin
		o_timer_load   = 1'b0;
		o_timer_cycles = `TIMER_W'(`READ_SETTLE_CYCLES);
		case (r_state)
			LOAD_RUN: o_timer_load = cmd.cmd_done && w_last_page;
			ERASE_WAIT: begin
				o_timer_load   = cmd.cmd_done;
				o_timer_cycles = `TIMER_W'(`ERASE_WAIT_CYCLES);
			end
			PROG_WAIT: begin
				o_timer_load   = cmd.cmd_done;
				o_timer_cycles = `TIMER_W'(`PROGRAM_WAIT_CYCLES);
			end
			default: ;
		endcase
	end

	// save_user beats save_factory beats load
	assign w_start_save  = (r_state == READY) && (i_save_user || i_save_factory);
	assign w_save_region = i_save_user ? REGION_USER : REGION_FACTORY;
	assign w_start_load  = (r_state == IDLE) || (r_state == VERIFY_START) ||
		((r_state == READY) && i_load_user && !w_start_save);
	assign w_load_region = (r_state == VERIFY_START) ? r_region : REGION_USER;

	always_ff @(posedge i_clk_50m or negedge i_rst_n) begin
		if (!i_rst_n) begin
			r_state      <= IDLE;
			r_region     <= REGION_USER;
			r_page_cnt   <= '0;
			r_flash_addr <= FLASH_USER_BASE;
			r_timing     <= 1'b0;
			o_move_start <= 1'b0;
			o_move_base  <= SRAM_USER_BASE;
			o_move_drain <= 1'b0;
			o_busy       <= 1'b0;
			o_load_done  <= 1'b0;
		end else begin
			o_move_start <= 1'b0;
			o_load_done  <= 1'b0;
			if (w_start_load) begin
				r_region     <= w_load_region;
				r_page_cnt   <= '0;
				r_flash_addr <= flash_base(w_load_region);
				o_move_start <= 1'b1;
				o_move_base  <= sram_base(w_load_region);
				o_move_drain <= 1'b0;
				o_busy       <= 1'b0;
				r_state      <= LOAD_CMD;
			end else if (w_start_save) begin
				// both saves drain the user area
				r_region     <= w_save_region;
				r_page_cnt   <= '0;
				r_flash_addr <= flash_base(w_save_region);
				r_timing     <= 1'b0;
				o_move_start <= 1'b1;
				o_move_base  <= sram_base(REGION_USER);
				o_move_drain <= 1'b1;
				o_busy       <= 1'b1;
				r_state      <= ERASE_CMD;
			end else begin
				case (r_state)
					LOAD_CMD: if (w_accepted) r_state <= LOAD_RUN;
					LOAD_RUN: begin
						if (cmd.cmd_done) begin
							r_page_cnt   <= r_page_cnt + 1'b1;
							r_flash_addr <= r_flash_addr + `FLASH_ADDR_W'(`PAGE_BYTES);
							r_state      <= w_last_page ? LOAD_SETTLE : LOAD_CMD;
						end
					end
					LOAD_SETTLE: begin
						if (i_timer_done) begin
							o_load_done <= 1'b1;
							r_state     <= READY;
						end
					end
					ERASE_CMD: if (w_accepted) r_state <= ERASE_WAIT;
					ERASE_WAIT: begin
						if (cmd.cmd_done) begin
							r_timing <= 1'b1;
						end else if (r_timing && i_timer_done) begin
							r_timing <= 1'b0;
							r_state  <= PROG_CMD;
						end
					end
					PROG_CMD: if (w_accepted) r_state <= PROG_WAIT;
					PROG_WAIT: begin
						if (cmd.cmd_done) begin
							r_timing <= 1'b1;
						end else if (r_timing && i_timer_done) begin
							r_timing     <= 1'b0;
							r_page_cnt   <= r_page_cnt + 1'b1;
							r_flash_addr <= r_flash_addr + `FLASH_ADDR_W'(`PAGE_BYTES);
							if (w_last_page) begin
								r_state <= VERIFY_START;
							end else if (((int'(r_page_cnt) + 1) % `SECTOR_PAGES) == 0) begin
								r_state <= ERASE_CMD;
							end else begin
								r_state <= PROG_CMD;
							end
						end
					end
					default: ;
				endcase
			end
		end
	end

endmodule

/* hdl/spi_flash_master.sv */
`timescale 1ns/1ns
`include "flash_settings.svh"

module spi_flash_master (
	input  logic     i_clk_50m,
	input  logic     i_rst_n,
	spi_cmd_if.engine cmd,
	output logic     o_flash_cs_n,
	output logic     o_flash_sclk,
	output logic     o_flash_mosi,
	input  logic     i_flash_miso
);
	import flash_types_pkg::*;
	import flash_map_pkg::*;

	localparam int DIV_W = $clog2(`SPI_HALF_CYCLES + 1);

	typedef enum logic [1:0] {
		ENG_IDLE,
		ENG_SHIFT,
		ENG_TAIL
	} eng_state_t;

	eng_state_t            r_state;
	logic [DIV_W-1:0]      r_div_cnt;
	logic [2:0]            r_bit_cnt;
	logic [`CMD_LEN_W-1:0] r_byte_cnt;
	logic [`CMD_LEN_W-1:0] r_last_idx;
	flash_op_t             r_op;
	flash_addr_t           r_addr;
	logic [7:0]            r_tx_shift;
	logic [7:0]            r_rx_shift;
	logic                  w_half_end;
	logic [`CMD_LEN_W-1:0] w_next_idx;
	logic [7:0]            w_next_byte;

	assign w_half_end = (r_div_cnt == DIV_W'(`SPI_HALF_CYCLES - 1));
	assign w_next_idx = r_byte_cnt + 1'b1;

	// byte 0 opcode, 1..3 address, then data
	always_comb begin
		case (w_next_idx)
			`CMD_LEN_W'(1): w_next_byte = r_addr[23:16];
			`CMD_LEN_W'(2): w_next_byte = r_addr[15:8];
			`CMD_LEN_W'(3): w_next_byte = r_addr[7:0];
			default:        w_next_byte = (r_op == OP_PROGRAM) ? cmd.tx_byte : 8'h00;
		endcase
	end

	assign cmd.cmd_ready = (r_state == ENG_IDLE);
	assign cmd.rx_byte   = r_rx_shift;
	assign o_flash_mosi  = r_tx_shift[7] & ~o_flash_cs_n;

	always_ff @(posedge i_clk_50m or negedge i_rst_n) begin
		if (!i_rst_n) begin
			r_state      <= ENG_IDLE;
			r_div_cnt    <= '0;
			r_bit_cnt    <= '0;
			r_byte_cnt   <= '0;
			o_flash_cs_n <= 1'b1;
			o_flash_sclk <= 1'b0;
			cmd.cmd_done <= 1'b0;
			cmd.tx_req   <= 1'b0;
			cmd.rx_valid <= 1'b0;
		end else begin
			cmd.cmd_done <= 1'b0;
			cmd.tx_req   <= 1'b0;
			cmd.rx_valid <= 1'b0;
			case (r_state)
				ENG_IDLE: begin
					if (cmd.cmd_valid && cmd.cmd_ready) begin
						o_flash_cs_n <= 1'b0;
						r_div_cnt    <= '0;
						r_bit_cnt    <= '0;
						r_byte_cnt   <= '0;
						r_state      <= ENG_SHIFT;
					end
				end
				ENG_SHIFT: begin
					r_div_cnt <= w_half_end ? '0 : r_div_cnt + 1'b1;
					if (w_half_end) begin
						o_flash_sclk <= ~o_flash_sclk;
						// a falling edge closes the bit
						if (o_flash_sclk) begin
							r_bit_cnt <= r_bit_cnt + 1'b1;
							if (r_bit_cnt == 3'd7) begin
								if (r_op == OP_READ && r_byte_cnt >= `CMD_LEN_W'(4))
									cmd.rx_valid <= 1'b1;
								if (r_byte_cnt == r_last_idx) begin
									r_state <= ENG_TAIL;
								end else begin
									r_byte_cnt <= w_next_idx;
									// fetch one byte ahead of the data phase
									if (r_op == OP_PROGRAM && w_next_idx >= `CMD_LEN_W'(3) &&
										w_next_idx < r_last_idx)
										cmd.tx_req <= 1'b1;
								end
							end
						end
					end
				end
				ENG_TAIL: begin
					r_div_cnt <= w_half_end ? '0 : r_div_cnt + 1'b1;
					if (w_half_end) begin
						o_flash_cs_n <= 1'b1;
						cmd.cmd_done <= 1'b1;
						r_state      <= ENG_IDLE;
					end
				end
				default: r_state <= ENG_IDLE;
			endcase
		end
	end

	// command fields and shift registers
	always_ff @(posedge i_clk_50m) begin
		if (r_state == ENG_IDLE && cmd.cmd_valid) begin
			r_op       <= cmd.cmd_op;
			r_addr     <= cmd.cmd_addr;
			r_last_idx <= cmd.cmd_len + `CMD_LEN_W'(3);
			r_tx_shift <= cmd.cmd_op;
		end else if (r_state == ENG_SHIFT && w_half_end) begin
			if (!o_flash_sclk) begin
				r_rx_shift <= {r_rx_shift[6:0], i_flash_miso};
			end else if (r_bit_cnt == 3'd7) begin
				r_tx_shift <= w_next_byte;
			end else begin
				r_tx_shift <= {r_tx_shift[6:0], 1'b0};
			end
		end
	end

endmodule

/* hdl/sram_page_mover.sv */
`timescale 1ns/1ns
`include "flash_settings.svh"

module sram_page_mover (
	input  logic                      i_clk_50m,
	input  logic                      i_rst_n,
	input  logic                      i_start,
	input  flash_map_pkg::sram_addr_t i_base,
	input  logic                      i_drain,
	spi_cmd_if.mover                  bus,
	output logic                      o_sram_cs,
	output logic                      o_sram_we_n,
	output logic                      o_sram_rd_n,
	output flash_map_pkg::sram_addr_t o_sram_addr,
	output logic [`SRAM_DATA_W-1:0]   o_sram_wdata,
	input  logic [`SRAM_DATA_W-1:0]   i_sram_rdata
);
	import flash_map_pkg::*;

	localparam int REGION_WORDS = `REGION_PAGES * `PAGE_BYTES / 2;

	logic       r_odd;
	sram_addr_t r_moved;
	logic [7:0] r_hi_byte;
	logic [7:0] r_lo_byte;
	logic [7:0] r_tx_byte;

	assign bus.tx_byte = r_tx_byte;

	always_ff @(posedge i_clk_50m or negedge i_rst_n) begin
		if (!i_rst_n) begin
			o_sram_cs   <= 1'b0;
			o_sram_we_n <= 1'b1;
			o_sram_rd_n <= 1'b1;
			o_sram_addr <= '0;
			r_odd       <= 1'b0;
			r_moved     <= '0;
		end else if (i_start) begin
			o_sram_cs   <= 1'b1;
			o_sram_we_n <= 1'b1;
			o_sram_rd_n <= 1'b1;
			o_sram_addr <= i_base;
			r_odd       <= 1'b0;
			r_moved     <= '0;
		end else begin
			// single-cycle access, then next word
			if (!o_sram_we_n || !o_sram_rd_n) begin
				o_sram_we_n <= 1'b1;
				o_sram_rd_n <= 1'b1;
				o_sram_addr <= o_sram_addr + 1'b1;
				r_moved     <= r_moved + 1'b1;
				if (r_moved == sram_addr_t'(REGION_WORDS - 1))
					o_sram_cs <= 1'b0;
			end
			if (o_sram_cs && !i_drain && bus.rx_valid) begin
				r_odd <= ~r_odd;
				if (r_odd)
					o_sram_we_n <= 1'b0;
			end
			if (o_sram_cs && i_drain && bus.tx_req) begin
				r_odd <= ~r_odd;
				if (!r_odd)
					o_sram_rd_n <= 1'b0;
			end
		end
	end

	// first flash byte is the high half of the word
	always_ff @(posedge i_clk_50m) begin
		if (bus.rx_valid && !r_odd)
			r_hi_byte <= bus.rx_byte;
		if (bus.rx_valid && r_odd)
			o_sram_wdata <= {r_hi_byte, bus.rx_byte};
		if (!o_sram_rd_n) begin
			r_tx_byte <= i_sram_rdata[15:8];
			r_lo_byte <= i_sram_rdata[7:0];
		end else if (bus.tx_req && r_odd) begin
			r_tx_byte <= r_lo_byte;
		end
	end

endmodule

/* hdl/flash_control.sv */
`timescale 1ns/1ns
`include "flash_settings.svh"

module flash_control (
	input  logic                    i_clk_50m,
	input  logic                    i_rst_n,
	output logic                    o_flash_cs_n,
	output logic                    o_flash_sclk,
	output logic                    o_flash_mosi,
	input  logic                    i_flash_miso,
	output logic                    o_sram_cs,
	output logic                    o_sram_we_n,
	output logic                    o_sram_rd_n,
	output logic [`SRAM_ADDR_W-1:0] o_sram_addr,
	output logic [`SRAM_DATA_W-1:0] o_sram_wdata,
	input  logic [`SRAM_DATA_W-1:0] i_sram_rdata,
	input  logic                    i_load_user,
	input  logic                    i_save_user,
	input  logic                    i_save_factory,
	output logic                    o_busy,
	output logic                    o_load_done
);
	import flash_map_pkg::*;

	logic                w_timer_load;
	logic [`TIMER_W-1:0] w_timer_cycles;
	logic                w_timer_done;
	logic                w_move_start;
	sram_addr_t          w_move_base;
	logic                w_move_drain;

	spi_cmd_if u_cmd ();

	flash_sequencer u_seq (
		.i_clk_50m      (i_clk_50m),
		.i_rst_n        (i_rst_n),
		.i_load_user    (i_load_user),
		.i_save_user    (i_save_user),
		.i_save_factory (i_save_factory),
		.cmd            (u_cmd.seq),
		.o_timer_load   (w_timer_load),
		.o_timer_cycles (w_timer_cycles),
		.i_timer_done   (w_timer_done),
		.o_move_start   (w_move_start),
		.o_move_base    (w_move_base),
		.o_move_drain   (w_move_drain),
		.o_busy         (o_busy),
		.o_load_done    (o_load_done)
	);

	flash_wait_timer u_timer (
		.i_clk_50m (i_clk_50m),
		.i_rst_n   (i_rst_n),
		.i_load    (w_timer_load),
		.i_cycles  (w_timer_cycles),
		.o_done    (w_timer_done)
	);

	spi_flash_master u_spi (
		.i_clk_50m    (i_clk_50m),
		.i_rst_n      (i_rst_n),
		.cmd          (u_cmd.engine),
		.o_flash_cs_n (o_flash_cs_n),
		.o_flash_sclk (o_flash_sclk),
		.o_flash_mosi (o_flash_mosi),
		.i_flash_miso (i_flash_miso)
	);

	sram_page_mover u_mover (
		.i_clk_50m    (i_clk_50m),
		.i_rst_n      (i_rst_n),
		.i_start      (w_move_start),
		.i_base       (w_move_base),
		.i_drain      (w_move_drain),
		.bus          (u_cmd.mover),
		.o_sram_cs    (o_sram_cs),
		.o_sram_we_n  (o_sram_we_n),
		.o_sram_rd_n  (o_sram_rd_n),
		.o_sram_addr  (o_sram_addr),
		.o_sram_wdata (o_sram_wdata),
		.i_sram_rdata (i_sram_rdata)
	);

endmodule

/* bench/spi_flash_model.sv */
`timescale 1ns/1ns

module spi_flash_model (
	input  logic i_clk,
	input  logic i_cs_n,
	input  logic i_sclk,
	input  logic i_mosi,
	output logic o_miso
);

	// only the user and factory sectors exist
	localparam logic [23:0] BASE = 24'h0A0000;
	localparam int MEM_BYTES = 2 * 65536;

	logic [7:0]  mem [0:MEM_BYTES-1];
	logic [7:0]  page_buf [0:255];
	logic [7:0]  frame_op;
	logic [23:0] frame_addr;
	logic [7:0]  r_shift;
	logic        prev_cs_n = 1'b1;
	logic        prev_sclk = 1'b0;
	bit          dirty [0:511];
	int          bit_cnt;
	int          byte_cnt;
	int          errors;
	int          frames;
	int          prog_pages;

	function automatic bit in_range(logic [23:0] a);
		return (a >= BASE) && (a < BASE + MEM_BYTES);
	endfunction

	task automatic fill_region(int ofs);
		for (int i = 0; i < 65536; i++)
			mem[ofs + i] = 8'($urandom);
		for (int p = 0; p < 256; p++)
			dirty[(ofs >> 8) + p] = 1'b1;
	endtask

	task automatic take_bit();
		r_shift = {r_shift[6:0], i_mosi};
		bit_cnt++;
		if (bit_cnt == 8) begin
			bit_cnt = 0;
			if (byte_cnt == 0) begin
				frame_op = r_shift;
				assert (r_shift inside {8'h02, 8'h03, 8'hD8}) else begin
					$display("Fail t=%0t opcode expected=02/03/D8 actual=%h", $time, r_shift);
					errors++;
				end
			end else if (byte_cnt < 4) begin
				frame_addr = {frame_addr[15:0], r_shift};
			end else if (byte_cnt < 260) begin
				page_buf[byte_cnt - 4] = r_shift;
			end
			byte_cnt++;
			if (byte_cnt == 4) begin
				assert (in_range(frame_addr)) else begin
					$display("Address %h lies outside the modeled sectors", frame_addr);
					errors++;
				end
			end
		end
	endtask

	task automatic end_frame();
		int ofs;
		ofs = int'(frame_addr - BASE);
		if (frame_op == 8'h02) begin
			assert (byte_cnt == 260) else begin
				$display("Fail t=%0t program_len expected=260 actual=%0d", $time, byte_cnt);
				errors++;
			end
			assert (frame_addr[7:0] == 8'h00) else begin
				$display("Program at %h is not page aligned", frame_addr);
				errors++;
			end
			assert (!dirty[ofs >> 8]) else begin
				$display("Program at %h without an erase of its sector", frame_addr);
				errors++;
			end
			// programming only clears bits
			if (in_range(frame_addr)) begin
				for (int i = 0; i < 256; i++)
					mem[ofs + i] = mem[ofs + i] & page_buf[i];
				dirty[ofs >> 8] = 1'b1;
			end
			prog_pages++;
		end else if (frame_op == 8'hD8) begin
			assert (byte_cnt == 4) else begin
				$display("Fail t=%0t erase_len expected=4 actual=%0d", $time, byte_cnt);
				errors++;
			end
			if (in_range(frame_addr)) begin
				ofs = ofs & 32'hF0000;
				for (int i = 0; i < 65536; i++)
					mem[ofs + i] = 8'hFF;
				for (int p = 0; p < 256; p++)
					dirty[(ofs >> 8) + p] = 1'b0;
			end
		end
	endtask

	// sclk edges sampled on the falling clock edge away from DUT updates
	always @(negedge i_clk) begin
		if (prev_cs_n && !i_cs_n) begin
			bit_cnt  = 0;
			byte_cnt = 0;
			frames++;
			o_miso   = 1'b0;
		end else if (!prev_cs_n && i_cs_n) begin
			end_frame();
		end else if (!i_cs_n && i_sclk && !prev_sclk) begin
			take_bit();
		end else if (!i_cs_n && !i_sclk && prev_sclk && frame_op == 8'h03 &&
			byte_cnt >= 4 && byte_cnt < 260) begin
			o_miso = mem[int'(frame_addr - BASE) + byte_cnt - 4][7 - bit_cnt];
		end
		prev_cs_n = i_cs_n;
		prev_sclk = i_sclk;
	end

endmodule

/* bench/tb_flash_control.sv */
`timescale 1ns/1ns
`include "flash_settings.svh"

module tb_flash_control;

	localparam int FRAME_CYCLES = (`PAGE_BYTES + 4) * 16 * `SPI_HALF_CYCLES;
	localparam int LOAD_CYCLES = `REGION_PAGES * FRAME_CYCLES + `READ_SETTLE_CYCLES;
	localparam int SAVE_CYCLES = 64 * `SPI_HALF_CYCLES + `ERASE_WAIT_CYCLES +
		`REGION_PAGES * (FRAME_CYCLES + `PROGRAM_WAIT_CYCLES) + LOAD_CYCLES;
	// three times the length of boot, reload and both saves
	localparam int CYCLE_LIMIT = 3 * (2 * LOAD_CYCLES + 2 * SAVE_CYCLES + 2000);
	localparam int REGION_WORDS = `REGION_PAGES * `PAGE_BYTES / 2;
	localparam int FACTORY_OFS = 32'h10000;
	localparam int SRAM_FACTORY = 32'h8000;
	localparam int REQ_LOAD = 0;
	localparam int REQ_USER = 1;
	localparam int REQ_FACTORY = 2;

	typedef logic [15:0] region_words_t [REGION_WORDS];

	logic                    i_clk_50m = 1'b0;
	logic                    i_rst_n;
	logic                    i_load_user;
	logic                    i_save_user;
	logic                    i_save_factory;
	logic                    o_flash_cs_n;
	logic                    o_flash_sclk;
	logic                    o_flash_mosi;
	logic                    i_flash_miso;
	logic                    o_sram_cs;
	logic                    o_sram_we_n;
	logic                    o_sram_rd_n;
	logic [`SRAM_ADDR_W-1:0] o_sram_addr;
	logic [`SRAM_DATA_W-1:0] o_sram_wdata;
	logic [`SRAM_DATA_W-1:0] i_sram_rdata;
	logic                    o_busy;
	logic                    o_load_done;
	logic                    fill_user;
	logic [15:0]             sram [0:(1 << `SRAM_ADDR_W)-1];
	region_words_t           user_words;
	region_words_t           user_snapshot;
	int                      cycles;
	int                      checks;
	int                      errors;
	int                      done_count;

	always #10 i_clk_50m = ~i_clk_50m;

	flash_control i_dut (.*);

	spi_flash_model u_flash (
		.i_clk  (i_clk_50m),
		.i_cs_n (o_flash_cs_n),
		.i_sclk (o_flash_sclk),
		.i_mosi (o_flash_mosi),
		.o_miso (i_flash_miso)
	);

	// asynchronous-read SRAM
	assign i_sram_rdata = !o_sram_rd_n ? sram[o_sram_addr] : 16'h0000;

	always @(posedge i_clk_50m) begin
		if (fill_user) begin
			for (int k = 0; k < REGION_WORDS; k++)
				sram[k] <= user_words[k];
		end else if (o_sram_cs && !o_sram_we_n) begin
			sram[o_sram_addr] <= o_sram_wdata;
		end
	end

	always @(negedge i_clk_50m) begin
		if (o_load_done)
			done_count++;
	end

	always @(posedge i_clk_50m) begin
		cycles++;
		if (cycles >= CYCLE_LIMIT) begin
			$display("Timeout after %0d cycles without finishing the test sequence", cycles);
			$display("Test failed");
			$finish;
		end
	end

	sram_access_in_cs: assert property (@(posedge i_clk_50m) disable iff (!i_rst_n)
		(!o_sram_we_n || !o_sram_rd_n) |-> o_sram_cs)
		else begin
			$display("SRAM access at %0t with o_sram_cs low", $time);
			errors++;
		end

	task automatic check_value(input string name, input logic [31:0] exp, input logic [31:0] act);
		checks++;
		assert (act === exp) else begin
			$display("Fail t=%0t %s expected=%h actual=%h", $time, name, exp, act);
			errors++;
		end
	endtask

	// word k holds flash bytes 2k and 2k+1, first byte high
	task automatic check_sram_region(input int sram_base, input int flash_ofs);
		for (int k = 0; k < REGION_WORDS; k++)
			check_value($sformatf("sram[%0h]", sram_base + k),
				{u_flash.mem[flash_ofs + 2*k], u_flash.mem[flash_ofs + 2*k + 1]},
				sram[sram_base + k]);
	endtask

	task automatic check_flash_region(input int flash_ofs, input region_words_t words);
		for (int k = 0; k < REGION_WORDS; k++)
			check_value($sformatf("flash[%0h]", flash_ofs + 2*k), words[k],
				{u_flash.mem[flash_ofs + 2*k], u_flash.mem[flash_ofs + 2*k + 1]});
	endtask

	task automatic pulse_request(input int which);
		@(posedge i_clk_50m);
		#2;
		i_load_user    = (which == REQ_LOAD);
		i_save_user    = (which == REQ_USER);
		i_save_factory = (which == REQ_FACTORY);
		@(posedge i_clk_50m);
		#2;
		i_load_user    = 1'b0;
		i_save_user    = 1'b0;
		i_save_factory = 1'b0;
	endtask

	task automatic wait_load_done();
		@(negedge i_clk_50m);
		while (!o_load_done)
			@(negedge i_clk_50m);
	endtask

	task automatic run_save(input int which);
		int prog_start;
		int done_start;
		int frames_start;
		int frames_end;
		prog_start   = u_flash.prog_pages;
		done_start   = done_count;
		frames_start = u_flash.frames;
		pulse_request(which);
		@(negedge i_clk_50m);
		check_value("o_busy", 1, o_busy);
		// dropped while busy
		pulse_request(REQ_LOAD);
		while (o_busy)
			@(negedge i_clk_50m);
		check_value("programmed_pages", `REGION_PAGES, u_flash.prog_pages - prog_start);
		// one erase and the page programs, verify read not yet begun
		check_value("save_frames", frames_start + 1 + `REGION_PAGES, u_flash.frames);
		wait_load_done();
		frames_end = u_flash.frames;
		repeat (200) @(negedge i_clk_50m);
		check_value("flash_frames", frames_end, u_flash.frames);
		check_value("load_done_count", done_start + 1, done_count);
	endtask

	initial begin
		void'($urandom(43574));
		i_rst_n        = 1'b0;
		i_load_user    = 1'b0;
		i_save_user    = 1'b0;
		i_save_factory = 1'b0;
		fill_user      = 1'b0;
		u_flash.fill_region(0);
		u_flash.fill_region(FACTORY_OFS);
		repeat (16) @(posedge i_clk_50m);
		#2;
		i_rst_n = 1'b1;
		@(negedge i_clk_50m);
		check_value("o_flash_cs_n", 1, o_flash_cs_n);
		check_value("o_flash_sclk", 0, o_flash_sclk);
		check_value("o_sram_cs", 0, o_sram_cs);
		check_value("o_sram_we_n", 1, o_sram_we_n);
		check_value("o_sram_rd_n", 1, o_sram_rd_n);
		check_value("o_busy", 0, o_busy);

		// boot load
		wait_load_done();
		check_sram_region(0, 0);

		// save user
		for (int k = 0; k < REGION_WORDS; k++)
			user_words[k] = 16'($urandom);
		@(posedge i_clk_50m);
		#2;
		fill_user = 1'b1;
		@(posedge i_clk_50m);
		#2;
		fill_user = 1'b0;
		run_save(REQ_USER);
		check_flash_region(0, user_words);
		check_sram_region(0, 0);

		// save factory
		for (int k = 0; k < REGION_WORDS; k++)
			user_snapshot[k] = {u_flash.mem[2*k], u_flash.mem[2*k + 1]};
		run_save(REQ_FACTORY);
		check_flash_region(FACTORY_OFS, user_words);
		check_flash_region(0, user_snapshot);
		check_sram_region(SRAM_FACTORY, FACTORY_OFS);

		// reload after new flash content
		@(posedge i_clk_50m);
		#2;
		u_flash.fill_region(0);
		pulse_request(REQ_LOAD);
		wait_load_done();
		check_sram_region(0, 0);

		$display("Checks: %0d, errors: %0d bench, %0d flash model", checks, errors,
			u_flash.errors);
		if (errors == 0 && u_flash.errors == 0) begin
			$display("Test completed successfully");
		end else begin
			$display("Test failed");
		end
		$finish;
	end

endmodule

/* flash_control.f */
+incdir+hdl
hdl/flash_types_pkg.sv
hdl/flash_map_pkg.sv
hdl/spi_cmd_if.sv
hdl/flash_wait_timer.sv
hdl/flash_sequencer.sv
hdl/spi_flash_master.sv
hdl/sram_page_mover.sv
hdl/flash_control.sv
bench/spi_flash_model.sv
bench/tb_flash_control.sv

/* run_sim.sh */
#!/bin/sh
# Build and run the flash_control testbench with Verilator.

cd "$(dirname "$0")" || exit 1

verilator --binary --timing --assert \
	--top-module tb_flash_control \
	-f flash_control.f \
	--Mdir obj_dir -o sim_flash_control
if [ $? -ne 0 ]; then
	echo "Verilator build failed"
	exit 1
fi

./obj_dir/sim_flash_control > sim.log 2>&1
if [ $? -ne 0 ]; then
	cat sim.log
	echo "Simulation exited with an error"
	exit 1
fi

cat sim.log
if grep -q "Test completed successfully" sim.log; then
	exit 0
fi
exit 1
